//--- design/dp_pkg.sv
package dp_pkg;

	// Bus, register and memory sizes
	localparam int DATA_W = 32;
	localparam int NUM_GPR = 16;
	localparam int GPR_SEL_W = $clog2(NUM_GPR);
	localparam int SHAMT_W = $clog2(DATA_W);
	localparam int ADDR_W = 9;
	localparam int MEM_DEPTH = 512;

	// Instruction register fields
	localparam int RA_LSB = 23;
	localparam int RB_LSB = 19;
	localparam int RC_LSB = 15;
	localparam int C_W = 19;
	// Branch condition code sits in the low bits of the rb field
	localparam int COND_W = 2;

	typedef enum logic [4:0] {
		ALU_ADD  = 5'd0,
		ALU_SUB  = 5'd1,
		ALU_AND  = 5'd2,
		ALU_OR   = 5'd3,
		ALU_SHR  = 5'd4,
		ALU_SHRA = 5'd5,
		ALU_SHL  = 5'd6,
		ALU_ROR  = 5'd7,
		ALU_ROL  = 5'd8,
		ALU_MUL  = 5'd9,
		ALU_DIV  = 5'd10,
		ALU_NEG  = 5'd11,
		ALU_NOT  = 5'd12
	} alu_op_t;

	// Codes 1 to 15 are left free, matching the per-register encoder layout
	typedef enum logic [4:0] {
		SRC_GPR    = 5'd0,
		SRC_HI     = 5'd16,
		SRC_LO     = 5'd17,
		SRC_ZHI    = 5'd18,
		SRC_ZLO    = 5'd19,
		SRC_PC     = 5'd20,
		SRC_MDR    = 5'd21,
		SRC_INPORT = 5'd22,
		SRC_CSIGN  = 5'd23,
		SRC_NONE   = 5'd31
	} bus_src_t;

endpackage

//--- design/gpr_if.sv
`timescale 1ns/100ps

interface gpr_if;
	import dp_pkg::*;

	// One-hot register selects from field decode
	logic [NUM_GPR-1:0] wr_en;
	logic [NUM_GPR-1:0] rd_sel;
	logic               ba_out;

	// Selected register word toward the bus
	logic [DATA_W-1:0]  rd_data;

	modport decode (output wr_en, rd_sel, ba_out);

	modport regs (input wr_en, rd_sel, ba_out, output rd_data);

	modport mux (input rd_data);

endinterface

//--- design/select_encode.sv
`timescale 1ns/100ps

module select_encode (
	input  logic [dp_pkg::DATA_W-1:0] ir_data,
	input  logic                      gra,
	input  logic                      grb,
	input  logic                      grc,
	input  logic                      r_in,
	input  logic                      r_out,
	input  logic                      ba_out,
	gpr_if.decode                     gpr,
	output logic [dp_pkg::DATA_W-1:0] c_sign_ext
);
	import dp_pkg::*;

	logic [GPR_SEL_W-1:0] reg_field;
	logic [NUM_GPR-1:0]   reg_onehot;
	logic                 field_valid;

	assign field_valid = gra | grb | grc;

	// Field pick with ra first when several are raised
	always_comb begin
		reg_field = '0;
		if (gra) begin
			reg_field = ir_data[RA_LSB +: GPR_SEL_W];
		end else if (grb) begin
			reg_field = ir_data[RB_LSB +: GPR_SEL_W];
		end else if (grc) begin
			reg_field = ir_data[RC_LSB +: GPR_SEL_W];
		end
	end

	// 4-to-16 decode
	always_comb begin
		reg_onehot = '0;
		if (field_valid)
			reg_onehot[reg_field] = 1'b1;
	end

	assign gpr.wr_en  = reg_onehot & {NUM_GPR{r_in}};
	assign gpr.rd_sel = reg_onehot & {NUM_GPR{r_out | ba_out}};
	assign gpr.ba_out = ba_out;

	// Immediate constant from the low IR bits
	assign c_sign_ext = {{(DATA_W - C_W){ir_data[C_W-1]}}, ir_data[C_W-1:0]};

endmodule

//--- design/reg_file.sv
`timescale 1ns/100ps

module reg_file (
	input  logic                      clk,
	input  logic                      rst,
	gpr_if.regs                       gpr,
	input  logic [dp_pkg::DATA_W-1:0] bus_data
);
	import dp_pkg::*;

	logic [DATA_W-1:0] regs [NUM_GPR];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_GPR; i++)
				regs[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_GPR; i++) begin
				if (gpr.wr_en[i])
					regs[i] <= bus_data;
			end
		end
	end

	// AND-OR read over the one-hot select
	always_comb begin
		gpr.rd_data = '0;
		for (int i = 0; i < NUM_GPR; i++) begin
			if (gpr.rd_sel[i])
				gpr.rd_data = gpr.rd_data | regs[i];
		end
		// r0 reads as zero when used as a base address
		if (gpr.ba_out && gpr.rd_sel[0])
			gpr.rd_data = '0;
	end

endmodule

//--- design/bus_mux.sv
`timescale 1ns/100ps

module bus_mux (
	input  logic                      r_out,
	input  logic                      ba_out,
	input  logic                      hi_out,
	input  logic                      lo_out,
	input  logic                      zhi_out,
	input  logic                      zlo_out,
	input  logic                      pc_out,
	input  logic                      mdr_out,
	input  logic                      inport_out,
	input  logic                      c_out,
	gpr_if.mux                        gpr,
	input  logic [dp_pkg::DATA_W-1:0] hi_data,
	input  logic [dp_pkg::DATA_W-1:0] lo_data,
	input  logic [dp_pkg::DATA_W-1:0] zhi_data,
	input  logic [dp_pkg::DATA_W-1:0] zlo_data,
	input  logic [dp_pkg::DATA_W-1:0] pc_data,
	input  logic [dp_pkg::DATA_W-1:0] mdr_data,
	input  logic [dp_pkg::DATA_W-1:0] inport_reg,
	input  logic [dp_pkg::DATA_W-1:0] c_sign_ext,
	output logic [dp_pkg::DATA_W-1:0] bus_data
);
	import dp_pkg::*;

	bus_src_t bus_src;

	// Strobe encoder
	always_comb begin
		bus_src = SRC_NONE;
		if (r_out | ba_out)
			bus_src = SRC_GPR;
		else if (hi_out)
			bus_src = SRC_HI;
		else if (lo_out)
			bus_src = SRC_LO;
		else if (zhi_out)
			bus_src = SRC_ZHI;
		else if (zlo_out)
			bus_src = SRC_ZLO;
		else if (pc_out)
			bus_src = SRC_PC;
		else if (mdr_out)
			bus_src = SRC_MDR;
		else if (inport_out)
			bus_src = SRC_INPORT;
		else if (c_out)
			bus_src = SRC_CSIGN;
	end

	always_comb begin
		case (bus_src)
			SRC_GPR:    bus_data = gpr.rd_data;
			SRC_HI:     bus_data = hi_data;
			SRC_LO:     bus_data = lo_data;
			SRC_ZHI:    bus_data = zhi_data;
			SRC_ZLO:    bus_data = zlo_data;
			SRC_PC:     bus_data = pc_data;
			SRC_MDR:    bus_data = mdr_data;
			SRC_INPORT: bus_data = inport_reg;
			SRC_CSIGN:  bus_data = c_sign_ext;
			default:    bus_data = '0;
		endcase
	end

endmodule

//--- design/alu_unit.sv
`timescale 1ns/100ps

module alu_unit (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      y_in,
	input  logic                      z_in,
	input  logic                      hi_in,
	input  logic                      lo_in,
	input  dp_pkg::alu_op_t           alu_op,
	input  logic [dp_pkg::DATA_W-1:0] bus_data,
	output logic [dp_pkg::DATA_W-1:0] hi_data,
	output logic [dp_pkg::DATA_W-1:0] lo_data,
	output logic [dp_pkg::DATA_W-1:0] zhi_data,
	output logic [dp_pkg::DATA_W-1:0] zlo_data
);
	import dp_pkg::*;

	logic [DATA_W-1:0]          y_q;
	logic [2*DATA_W-1:0]        z_q;
	logic [2*DATA_W-1:0]        alu_result;
	logic [SHAMT_W-1:0]         shamt;
	logic [2*DATA_W-1:0]        rot_r;
	logic [2*DATA_W-1:0]        rot_l;
	logic signed [2*DATA_W-1:0] product;
	logic                       div_zero;
	logic [DATA_W-1:0]          divisor;
	logic [DATA_W-1:0]          quotient;
	logic [DATA_W-1:0]          remainder;

	assign shamt = bus_data[SHAMT_W-1:0];

	// Rotates by shifting a doubled copy of A
	assign rot_r = {y_q, y_q} >> shamt;
	assign rot_l = {y_q, y_q} << shamt;

	assign product = $signed(y_q) * $signed(bus_data);

	// Divider never sees a zero divisor, the result is patched below
	assign div_zero  = (bus_data == '0);
	assign divisor   = div_zero ? {{(DATA_W-1){1'b0}}, 1'b1} : bus_data;
	assign quotient  = $signed(y_q) / $signed(divisor);
	assign remainder = $signed(y_q) % $signed(divisor);

	always_comb begin
		alu_result = '0;
		case (alu_op)
			ALU_ADD:  alu_result[DATA_W-1:0] = y_q + bus_data;
			ALU_SUB:  alu_result[DATA_W-1:0] = y_q - bus_data;
			ALU_AND:  alu_result[DATA_W-1:0] = y_q & bus_data;
			ALU_OR:   alu_result[DATA_W-1:0] = y_q | bus_data;
			ALU_SHR:  alu_result[DATA_W-1:0] = y_q >> shamt;
			ALU_SHRA: alu_result[DATA_W-1:0] = $signed(y_q) >>> shamt;
			ALU_SHL:  alu_result[DATA_W-1:0] = y_q << shamt;
			ALU_ROR:  alu_result[DATA_W-1:0] = rot_r[DATA_W-1:0];
			ALU_ROL:  alu_result[DATA_W-1:0] = rot_l[2*DATA_W-1:DATA_W];
			ALU_MUL:  alu_result = product;
			ALU_DIV:  alu_result = div_zero ? {y_q, {DATA_W{1'b1}}} : {remainder, quotient};
			ALU_NEG:  alu_result[DATA_W-1:0] = -bus_data;
			ALU_NOT:  alu_result[DATA_W-1:0] = ~bus_data;
			default:  alu_result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			y_q     <= '0;
			z_q     <= '0;
			hi_data <= '0;
			lo_data <= '0;
		end else begin
			if (y_in)
				y_q <= bus_data;
			if (z_in)
				z_q <= alu_result;
			if (hi_in)
				hi_data <= bus_data;
			if (lo_in)
				lo_data <= bus_data;
		end
	end

	assign zhi_data = z_q[2*DATA_W-1:DATA_W];
	assign zlo_data = z_q[DATA_W-1:0];

endmodule

//--- design/instr_unit.sv
`timescale 1ns/100ps

module instr_unit (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      pc_in,
	input  logic                      pc_inc,
	input  logic                      ir_in,
	input  logic                      con_in,
	input  logic [dp_pkg::DATA_W-1:0] bus_data,
	output logic [dp_pkg::DATA_W-1:0] pc_data,
	output logic [dp_pkg::DATA_W-1:0] ir_data,
	output logic                      con_out
);
	import dp_pkg::*;

	logic bus_zero;
	logic bus_neg;
	logic cond_met;

	assign bus_zero = (bus_data == '0);
	assign bus_neg  = bus_data[DATA_W-1];

	// Branch condition from the C2 field of the IR
	always_comb begin
		case (ir_data[RB_LSB +: COND_W])
			2'b00:   cond_met = bus_zero;
			2'b01:   cond_met = !bus_zero;
			2'b10:   cond_met = !bus_neg && !bus_zero;
			default: cond_met = bus_neg;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_data <= '0;
			ir_data <= '0;
			con_out <= 1'b0;
		end else begin
			// Increment wins over a bus load
			if (pc_inc)
				pc_data <= pc_data + 1'b1;
			else if (pc_in)
				pc_data <= bus_data;
			if (ir_in)
				ir_data <= bus_data;
			if (con_in)
				con_out <= cond_met;
		end
	end

endmodule

//--- design/mem_io_unit.sv
`timescale 1ns/100ps

module mem_io_unit (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      mar_in,
	input  logic                      mdr_in,
	input  logic                      read,
	input  logic                      write,
	input  logic                      out_in,
	input  logic [dp_pkg::DATA_W-1:0] bus_data,
	input  logic [dp_pkg::DATA_W-1:0] inport_data,
	output logic [dp_pkg::DATA_W-1:0] mdr_data,
	output logic [dp_pkg::DATA_W-1:0] inport_reg,
	output logic [dp_pkg::DATA_W-1:0] outport_data
);
	import dp_pkg::*;

	logic [ADDR_W-1:0] mar_q;
	logic [DATA_W-1:0] mem [MEM_DEPTH];
	logic [DATA_W-1:0] mem_rd;

	// Asynchronous read at the MAR address
	assign mem_rd = mem[mar_q];

	always_ff @(posedge clk) begin
		if (write)
			mem[mar_q] <= mdr_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mar_q        <= '0;
			mdr_data     <= '0;
			inport_reg   <= '0;
			outport_data <= '0;
		end else begin
			if (mar_in)
				mar_q <= bus_data[ADDR_W-1:0];
			// MDR source is memory on a read, else the bus
			if (mdr_in)
				mdr_data <= read ? mem_rd : bus_data;
			inport_reg <= inport_data;
			if (out_in)
				outport_data <= bus_data;
		end
	end

endmodule

//--- design/cpu_datapath.sv
`timescale 1ns/100ps

module cpu_datapath (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      pc_in,
	input  logic                      pc_inc,
	input  logic                      ir_in,
	input  logic                      con_in,
	input  logic                      y_in,
	input  logic                      z_in,
	input  logic                      hi_in,
	input  logic                      lo_in,
	input  logic                      mar_in,
	input  logic                      mdr_in,
	input  logic                      out_in,
	input  logic                      read,
	input  logic                      write,
	input  logic                      gra,
	input  logic                      grb,
	input  logic                      grc,
	input  logic                      r_in,
	input  logic                      r_out,
	input  logic                      ba_out,
	input  logic                      pc_out,
	input  logic                      hi_out,
	input  logic                      lo_out,
	input  logic                      zhi_out,
	input  logic                      zlo_out,
	input  logic                      mdr_out,
	input  logic                      inport_out,
	input  logic                      c_out,
	input  dp_pkg::alu_op_t           alu_op,
	input  logic [dp_pkg::DATA_W-1:0] inport_data,
	output logic [dp_pkg::DATA_W-1:0] bus_data,
	output logic [dp_pkg::DATA_W-1:0] outport_data,
	output logic [dp_pkg::DATA_W-1:0] pc_data,
	output logic                      con_out
);
	import dp_pkg::*;

	logic [DATA_W-1:0] ir_data;
	logic [DATA_W-1:0] c_sign_ext;
	logic [DATA_W-1:0] hi_data;
	logic [DATA_W-1:0] lo_data;
	logic [DATA_W-1:0] zhi_data;
	logic [DATA_W-1:0] zlo_data;
	logic [DATA_W-1:0] mdr_data;
	logic [DATA_W-1:0] inport_reg;

	gpr_if gpr ();

	select_encode u_select_encode (
		.ir_data(ir_data), .gra(gra), .grb(grb), .grc(grc),
		.r_in(r_in), .r_out(r_out), .ba_out(ba_out),
		.gpr(gpr.decode), .c_sign_ext(c_sign_ext)
	);

	reg_file u_reg_file (
		.clk(clk), .rst(rst), .gpr(gpr.regs), .bus_data(bus_data)
	);

	bus_mux u_bus_mux (
		.r_out(r_out), .ba_out(ba_out), .hi_out(hi_out), .lo_out(lo_out),
		.zhi_out(zhi_out), .zlo_out(zlo_out), .pc_out(pc_out), .mdr_out(mdr_out),
		.inport_out(inport_out), .c_out(c_out), .gpr(gpr.mux),
		.hi_data(hi_data), .lo_data(lo_data), .zhi_data(zhi_data), .zlo_data(zlo_data),
		.pc_data(pc_data), .mdr_data(mdr_data), .inport_reg(inport_reg),
		.c_sign_ext(c_sign_ext), .bus_data(bus_data)
	);

	alu_unit u_alu_unit (
		.clk(clk), .rst(rst), .y_in(y_in), .z_in(z_in), .hi_in(hi_in), .lo_in(lo_in),
		.alu_op(alu_op), .bus_data(bus_data), .hi_data(hi_data), .lo_data(lo_data),
		.zhi_data(zhi_data), .zlo_data(zlo_data)
	);

	instr_unit u_instr_unit (
		.clk(clk), .rst(rst), .pc_in(pc_in), .pc_inc(pc_inc), .ir_in(ir_in),
		.con_in(con_in), .bus_data(bus_data), .pc_data(pc_data), .ir_data(ir_data),
		.con_out(con_out)
	);

	mem_io_unit u_mem_io_unit (
		.clk(clk), .rst(rst), .mar_in(mar_in), .mdr_in(mdr_in), .read(read),
		.write(write), .out_in(out_in), .bus_data(bus_data), .inport_data(inport_data),
		.mdr_data(mdr_data), .inport_reg(inport_reg), .outport_data(outport_data)
	);

endmodule

//--- test/cpu_datapath_asserts.sv
`timescale 1ns/100ps

module cpu_datapath_asserts (
	input logic                      clk,
	input logic                      rst,
	input logic [9:0]                src_strobes,
	input logic                      read,
	input logic                      write,
	input logic [dp_pkg::DATA_W-1:0] outport_data
);

	// One bus driver per cycle
	a_single_source: assert property (@(posedge clk) disable iff (rst)
		$onehot0(src_strobes))
		else $error("Bus source strobes overlap: %b", src_strobes);

	a_no_read_write: assert property (@(posedge clk) disable iff (rst)
		!(read && write))
		else $error("Memory read and write raised together");

	// Output port cleared by reset
	a_outport_reset: assert property (@(posedge clk)
		rst |=> (outport_data == '0))
		else $error("Output port not zero after reset");

endmodule

bind cpu_datapath cpu_datapath_asserts u_asserts (
	.clk(clk),
	.rst(rst),
	.src_strobes({r_out, ba_out, hi_out, lo_out, zhi_out, zlo_out,
		pc_out, mdr_out, inport_out, c_out}),
	.read(read),
	.write(write),
	.outport_data(outport_data)
);

//--- test/tb_cpu_datapath.sv
`timescale 1ns/100ps

module tb_cpu_datapath;
	import dp_pkg::*;

	typedef enum {TO_IR, TO_GPR, TO_Y, TO_PC, TO_MAR, TO_MDR, TO_OUT, TO_CON} dest_t;
	typedef enum {FROM_GPR, FROM_BASE, FROM_ZHI, FROM_ZLO, FROM_PC, FROM_MDR, FROM_CONST} src_t;

	logic clk = 1'b0;
	logic rst;
	logic pc_in, pc_inc, ir_in, con_in, y_in, z_in, hi_in, lo_in;
	logic mar_in, mdr_in, out_in, read, write;
	logic gra, grb, grc, r_in, r_out, ba_out;
	logic pc_out, hi_out, lo_out, zhi_out, zlo_out, mdr_out, inport_out, c_out;
	alu_op_t alu_op;
	logic [DATA_W-1:0] inport_data;
	logic [DATA_W-1:0] bus_data;
	logic [DATA_W-1:0] outport_data;
	logic [DATA_W-1:0] pc_data;
	logic con_out;

	// Pending comparisons, filled by the tests and drained by the compare process
	string       name_q [$];
	logic [63:0] exp_q [$];
	logic [63:0] act_q [$];

	int error_count = 0;
	int check_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start = 0;
	bit run_ok = 1'b1;

	logic [DATA_W-1:0] gpr_model [NUM_GPR];
	logic [DATA_W-1:0] mem_model [MEM_DEPTH];

	cpu_datapath DUT (.*);

	always #2 clk = ~clk;

	// 64-bit ALU result worked out from the operation rules
	function automatic logic [63:0] alu_ref(input logic [31:0] a, input logic [31:0] b,
			input alu_op_t op);
		logic [4:0]  n;
		logic [31:0] lo;
		longint      sa;
		longint      sb;
		n  = b[4:0];
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		case (op)
			ALU_ADD:  lo = a + b;
			ALU_SUB:  lo = a - b;
			ALU_AND:  lo = a & b;
			ALU_OR:   lo = a | b;
			ALU_SHR:  lo = a >> n;
			ALU_SHRA: lo = 32'(sa >>> n);
			ALU_SHL:  lo = a << n;
			ALU_ROR:  lo = (a >> n) | (a << (6'd32 - n));
			ALU_ROL:  lo = (a << n) | (a >> (6'd32 - n));
			ALU_NEG:  lo = 32'd0 - b;
			ALU_NOT:  lo = ~b;
			default:  lo = '0;
		endcase
		if (op == ALU_MUL)
			return 64'(sa * sb);
		if (op == ALU_DIV)
			return (b == '0) ? {a, 32'hffff_ffff} : {32'(sa % sb), 32'(sa / sb)};
		return {32'd0, lo};
	endfunction

	function automatic logic cond_ref(input int code, input logic [31:0] v);
		logic met;
		case (code)
			0:       met = (v == '0);
			1:       met = (v != '0);
			2:       met = !v[31] && (v != '0);
			default: met = v[31];
		endcase
		return met;
	endfunction

	task automatic compare_value(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("ERROR %s: expected 0x%h, got 0x%h", name, exp, act);
		end
	endtask

	// Compare process
	always @(negedge clk) begin
		while (exp_q.size() != 0)
			compare_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
	end

	task automatic queue_check(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	task automatic clear_strobes();
		{pc_in, pc_inc, ir_in, con_in, y_in, z_in, hi_in, lo_in} = '0;
		{mar_in, mdr_in, out_in, read, write} = '0;
		{gra, grb, grc, r_in, r_out, ba_out} = '0;
		{pc_out, hi_out, lo_out, zhi_out, zlo_out, mdr_out, inport_out, c_out} = '0;
		alu_op = ALU_ADD;
	endtask

	task automatic begin_cycle();
		@(negedge clk);
		clear_strobes();
	endtask

	// Idle cycle, then sample in the middle of the low phase
	task automatic settle();
		begin_cycle();
		#1;
	endtask

	// Port word is registered at the next edge and can be driven on the bus after it
	task automatic present(input logic [31:0] val);
		begin_cycle();
		inport_data = val;
	endtask

	task automatic load_bus(input logic [31:0] val, input dest_t dst);
		present(val);
		begin_cycle();
		inport_out = 1'b1;
		case (dst)
			TO_IR:  ir_in = 1'b1;
			TO_GPR: begin
				gra  = 1'b1;
				r_in = 1'b1;
			end
			TO_Y:   y_in   = 1'b1;
			TO_PC:  pc_in  = 1'b1;
			TO_MAR: mar_in = 1'b1;
			TO_MDR: mdr_in = 1'b1;
			TO_OUT: out_in = 1'b1;
			default: con_in = 1'b1;
		endcase
	endtask

	task automatic expect_bus(input string name, input src_t src, input logic [31:0] exp);
		begin_cycle();
		case (src)
			FROM_GPR: begin
				gra   = 1'b1;
				r_out = 1'b1;
			end
			FROM_BASE: begin
				gra    = 1'b1;
				ba_out = 1'b1;
			end
			FROM_ZHI: zhi_out = 1'b1;
			FROM_ZLO: zlo_out = 1'b1;
			FROM_PC:  pc_out  = 1'b1;
			FROM_MDR: mdr_out = 1'b1;
			default:  c_out   = 1'b1;
		endcase
		#1;
		queue_check(name, 64'(exp), 64'(bus_data));
	endtask

	task automatic alu_exec(input logic [31:0] a, input logic [31:0] b, input alu_op_t op);
		load_bus(a, TO_Y);
		present(b);
		begin_cycle();
		inport_out = 1'b1;
		alu_op     = op;
		z_in       = 1'b1;
	endtask

	task automatic fetch_word(input logic [ADDR_W-1:0] addr, input logic [31:0] exp);
		load_bus(32'(addr), TO_MAR);
		// Overwrite MDR so the read has to replace it
		load_bus(~exp, TO_MDR);
		begin_cycle();
		read   = 1'b1;
		mdr_in = 1'b1;
		expect_bus("mdr_data", FROM_MDR, exp);
	endtask

	task automatic finish_test(input string name);
		int n;
		begin_cycle();
		for (n = 0; n < 16 && exp_q.size() != 0; n++)
			@(negedge clk);
		if (exp_q.size() != 0) begin
			$display("Timeout: %s left %0d checks unprocessed", name, exp_q.size());
			run_ok = 1'b0;
		end else begin
			tests_run++;
			if (error_count != errors_at_start)
				tests_failed++;
			$display("%s: %0d errors", name, error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	task automatic check_reset_state();
		settle();
		queue_check("bus_data", 64'd0, 64'(bus_data));
		queue_check("pc_data", 64'd0, 64'(pc_data));
		queue_check("outport_data", 64'd0, 64'(outport_data));
		queue_check("con_out", 64'd0, 64'(con_out));
		finish_test("reset state");
	endtask

	task automatic gpr_round_trip();
		for (int k = 0; k < NUM_GPR; k++) begin
			gpr_model[k] = $urandom;
			load_bus(32'(k) << RA_LSB, TO_IR);
			load_bus(gpr_model[k], TO_GPR);
		end
		for (int k = NUM_GPR - 1; k >= 0; k--) begin
			load_bus(32'(k) << RA_LSB, TO_IR);
			expect_bus("bus_data(r_out)", FROM_GPR, gpr_model[k]);
		end
		load_bus(32'd0, TO_IR);
		expect_bus("bus_data(ba_out r0)", FROM_BASE, 32'd0);
		finish_test("register file");
	endtask

	task automatic alu_sweep();
		logic [31:0] a;
		logic [31:0] b;
		logic [63:0] z;
		alu_op_t     op;
		for (int i = 0; i < 200; i++) begin
			op = alu_op_t'(i % 13);
			a  = $urandom;
			b  = $urandom;
			// Some divides by zero
			if (op == ALU_DIV && (i % 3) == 1)
				b = '0;
			alu_exec(a, b, op);
			z = alu_ref(a, b, op);
			expect_bus("zhi_data", FROM_ZHI, z[63:32]);
			expect_bus("zlo_data", FROM_ZLO, z[31:0]);
		end
		finish_test("alu");
	endtask

	task automatic memory_round_trip();
		logic [ADDR_W-1:0] addr_list [32];
		logic [31:0]       v;
		for (int i = 0; i < 32; i++) begin
			addr_list[i] = ADDR_W'((i * 37 + 5) % MEM_DEPTH);
			v = $urandom;
			mem_model[addr_list[i]] = v;
			load_bus(32'(addr_list[i]), TO_MAR);
			load_bus(v, TO_MDR);
			begin_cycle();
			write = 1'b1;
			fetch_word(addr_list[i], v);
		end
		// Second pass against the scoreboard, after all stores
		for (int i = 0; i < 32; i++)
			fetch_word(addr_list[i], mem_model[addr_list[i]]);
		finish_test("memory");
	endtask

	task automatic branch_conditions();
		logic [31:0] v;
		for (int c = 0; c < 4; c++) begin
			for (int s = 0; s < 3; s++) begin
				if (s == 0)
					v = '0;
				else if (s == 1)
					v = ($urandom & 32'h7fff_ffff) | 32'd1;
				else
					v = $urandom | 32'h8000_0000;
				load_bus(32'(c) << RB_LSB, TO_IR);
				load_bus(v, TO_CON);
				settle();
				queue_check("con_out", 64'(cond_ref(c, v)), 64'(con_out));
			end
		end
		finish_test("branch condition");
	endtask

	task automatic pc_and_ports();
		logic [31:0] v;
		logic [31:0] ir;
		v = $urandom;
		load_bus(v, TO_PC);
		for (int n = 1; n <= 6; n++) begin
			begin_cycle();
			pc_inc = 1'b1;
			settle();
			queue_check("pc_data", 64'(v + 32'(n)), 64'(pc_data));
		end
		expect_bus("bus_data(pc_out)", FROM_PC, v + 32'd6);
		v = $urandom;
		load_bus(v, TO_OUT);
		settle();
		queue_check("outport_data", 64'(v), 64'(outport_data));
		// Constant sign bit set on the first pass and clear on the second
		for (int s = 0; s < 2; s++) begin
			ir = (s == 0) ? ($urandom | 32'h0004_0000) : ($urandom & 32'hfffb_ffff);
			load_bus(ir, TO_IR);
			expect_bus("bus_data(c_out)", FROM_CONST,
				(s == 0) ? (ir | 32'hfff8_0000) : (ir & 32'h0007_ffff));
		end
		finish_test("pc and ports");
	endtask

	initial begin
		void'($urandom(32'h6830));
		rst = 1'b1;
		clear_strobes();
		inport_data = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		check_reset_state();
		if (run_ok)
			gpr_round_trip();
		if (run_ok)
			alu_sweep();
		if (run_ok)
			memory_round_trip();
		if (run_ok)
			branch_conditions();
		if (run_ok)
			pc_and_ports();

		$display("Summary: %0d tests run, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_count, error_count);
		if (run_ok && error_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Overall limit on simulated time
	initial begin
		#200000;
		$display("Timeout: simulation ran past its time limit");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- files.f
design/dp_pkg.sv
design/gpr_if.sv
design/select_encode.sv
design/reg_file.sv
design/bus_mux.sv
design/alu_unit.sv
design/instr_unit.sv
design/mem_io_unit.sv
design/cpu_datapath.sv
test/cpu_datapath_asserts.sv
test/tb_cpu_datapath.sv

//--- Makefile
SIM := obj_dir/Vtb_cpu_datapath

.PHONY: run clean

$(SIM): files.f $(wildcard design/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_datapath -f files.f

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log
